/* hdl/ipv4_stamp_pkg.sv */
////////////////////
// Shared widths, typedefs, beat structs and fault bit
// positions for the IPv4 header stamper
////////////////////

package ipv4_stamp_pkg;

    ////////////////////
    // Widths

    localparam int HDR_WIDTH    = 160;
    localparam int CHKSUM_WIDTH = 16;
    localparam int SUM_WIDTH    = 20;
    localparam int FAULT_WIDTH  = 4;
    localparam int COUNT_WIDTH  = 16;

    // Checksum field sits in bits 79..64
    localparam int CHKSUM_LSB = 64;

    ////////////////////
    // Fault bit positions

    localparam int FAULT_VERSION = 0;
    localparam int FAULT_IHL     = 1;
    localparam int FAULT_TTL     = 2;
    localparam int FAULT_LENGTH  = 3;

    // Legal field values
    localparam logic [3:0]  IPV4_VERSION    = 4'd4;
    localparam logic [3:0]  IPV4_IHL_MIN    = 4'd5;
    localparam logic [15:0] IPV4_MIN_LENGTH = 16'd20;

    ////////////////////
    // Vector types

    // Whole header, version in the top bits
    typedef logic [HDR_WIDTH-1:0]    ipv4_hdr_t;
    typedef logic [CHKSUM_WIDTH-1:0] ip_chksum_t;
    // Unfolded sum of nine header words
    typedef logic [SUM_WIDTH-1:0]    hdr_sum_t;
    typedef logic [FAULT_WIDTH-1:0]  hdr_fault_t;
    typedef logic [COUNT_WIDTH-1:0]  hdr_count_t;

    ////////////////////
    // Beats

    typedef struct packed {
        logic      valid;
        ipv4_hdr_t hdr;
    } hdr_beat_t;

    typedef struct packed {
        logic       valid;
        ip_chksum_t chksum;
    } chksum_beat_t;

    // Screened header plus its fault flags
    typedef struct packed {
        logic       valid;
        ipv4_hdr_t  hdr;
        hdr_fault_t fault;
    } screened_beat_t;

    // Header with checksum written in
    typedef struct packed {
        logic       valid;
        ipv4_hdr_t  hdr;
        hdr_fault_t fault;
    } stamped_beat_t;

endpackage

/* hdl/ipv4_checksum_gen.sv */
////////////////////
// Two-stage ones'-complement IPv4 header checksum
////////////////////

module ipv4_checksum_gen (
    input  logic                        ipv4_header,
    input  logic                        rst_n,
    input  ipv4_stamp_pkg::hdr_beat_t   hdr_in,
    output ipv4_stamp_pkg::chksum_beat_t chksum
);

    import ipv4_stamp_pkg::*;

    ////////////////////
    // Declarations

    // Stage 1 sum, combinational and registered
    hdr_sum_t   sum_d;
    hdr_sum_t   sum_q;
    logic       valid_q;

    // Carry folds for stage 2
    logic [CHKSUM_WIDTH:0] fold_1;
    ip_chksum_t            fold_2;

    // Stage 2 output
    ip_chksum_t chksum_q;
    logic       chksum_valid_q;

    ////////////////////
    // Stage 1

    // Add all ten words except the checksum word
    always_comb begin
        sum_d = '0;
        for (int i = 0; i < HDR_WIDTH / CHKSUM_WIDTH; i++) begin
            if (i != CHKSUM_LSB / CHKSUM_WIDTH) begin
                sum_d = sum_d + hdr_sum_t'(hdr_in.hdr[i*CHKSUM_WIDTH +: CHKSUM_WIDTH]);
            end
        end
    end

    ////////////////////
    // Stage 2

    // Two folds leave no carry behind
    always_comb begin
        fold_1 = {1'b0, sum_q[CHKSUM_WIDTH-1:0]}
               + {{(CHKSUM_WIDTH + 1 - (SUM_WIDTH - CHKSUM_WIDTH)){1'b0}},
                  sum_q[SUM_WIDTH-1:CHKSUM_WIDTH]};
        fold_2 = fold_1[CHKSUM_WIDTH-1:0] + {{(CHKSUM_WIDTH-1){1'b0}}, fold_1[CHKSUM_WIDTH]};
    end

    // Valid pipe
    always_ff @(posedge ipv4_header) begin
        if (!rst_n) begin
            valid_q        <= 1'b0;
            chksum_valid_q <= 1'b0;
        end else begin
            valid_q        <= hdr_in.valid;
            chksum_valid_q <= valid_q;
        end
    end

    // Data pipe
    always_ff @(posedge ipv4_header) begin
        sum_q    <= sum_d;
        chksum_q <= ~fold_2;
    end

    assign chksum = '{valid: chksum_valid_q, chksum: chksum_q};

endmodule

/* hdl/ipv4_hdr_screen.sv */
////////////////////
// Two-stage fixed-field screen for IPv4 headers
////////////////////

module ipv4_hdr_screen (
    input  logic                           ipv4_header,
    input  logic                           rst_n,
    input  ipv4_stamp_pkg::hdr_beat_t      hdr_in,
    output ipv4_stamp_pkg::screened_beat_t screened
);

    import ipv4_stamp_pkg::*;

    ////////////////////
    // Declarations

    // Fields under test
    logic [3:0]  ip_version;
    logic [3:0]  ip_ihl;
    logic [15:0] ip_length;
    logic [7:0]  ip_ttl;
    logic        ip_rsvd_flag;

    hdr_fault_t  fault_d;

    // Stage 1 registers
    ipv4_hdr_t   hdr_s1;
    hdr_fault_t  fault_s1;
    logic        valid_s1;

    // Stage 2 registers
    ipv4_hdr_t   hdr_s2;
    hdr_fault_t  fault_s2;
    logic        valid_s2;

    ////////////////////
    // Field slices

    assign ip_version   = hdr_in.hdr[159:156];
    assign ip_ihl       = hdr_in.hdr[155:152];
    assign ip_length    = hdr_in.hdr[143:128];
    // Top flag bit, must be zero
    assign ip_rsvd_flag = hdr_in.hdr[111];
    assign ip_ttl       = hdr_in.hdr[95:88];

    // Fault flags, several may be set at once
    always_comb begin
        fault_d                = '0;
        fault_d[FAULT_VERSION] = (ip_version != IPV4_VERSION);
        // No options supported
        fault_d[FAULT_IHL]     = (ip_ihl != IPV4_IHL_MIN);
        fault_d[FAULT_TTL]     = (ip_ttl == '0);
        fault_d[FAULT_LENGTH]  = (ip_length < IPV4_MIN_LENGTH) | ip_rsvd_flag;
    end

    ////////////////////
    // Pipeline

    // Valid pipe, two stages to match the checksum path
    always_ff @(posedge ipv4_header) begin
        if (!rst_n) begin
            valid_s1 <= 1'b0;
            valid_s2 <= 1'b0;
        end else begin
            valid_s1 <= hdr_in.valid;
            valid_s2 <= valid_s1;
        end
    end

    // Header and flags ride along
    always_ff @(posedge ipv4_header) begin
        hdr_s1   <= hdr_in.hdr;
        fault_s1 <= fault_d;
        hdr_s2   <= hdr_s1;
        fault_s2 <= fault_s1;
    end

    assign screened = '{valid: valid_s2, hdr: hdr_s2, fault: fault_s2};

endmodule

/* hdl/ipv4_hdr_merge.sv */
////////////////////
// Checksum insertion, output register and event counters
////////////////////

module ipv4_hdr_merge (
    input  logic                           ipv4_header,
    input  logic                           rst_n,
    input  ipv4_stamp_pkg::chksum_beat_t   chksum,
    input  ipv4_stamp_pkg::screened_beat_t screened,
    output ipv4_stamp_pkg::stamped_beat_t  hdr_out,
    output ipv4_stamp_pkg::hdr_count_t     clean_count,
    output ipv4_stamp_pkg::hdr_count_t     fault_count
);

    import ipv4_stamp_pkg::*;

    ////////////////////
    // Declarations

    // Both paths have equal latency
    logic       beat_valid;
    logic       beat_clean;
    ipv4_hdr_t  stamped_hdr;

    // Output register
    logic       out_valid_q;
    ipv4_hdr_t  out_hdr_q;
    hdr_fault_t out_fault_q;

    // Counters
    hdr_count_t clean_q;
    hdr_count_t fault_q;

    ////////////////////
    // Merge

    assign beat_valid = screened.valid & chksum.valid;
    assign beat_clean = (screened.fault == '0);

    // Overwrite the checksum field only
    always_comb begin
        stamped_hdr = screened.hdr;
        stamped_hdr[CHKSUM_LSB +: CHKSUM_WIDTH] = chksum.chksum;
    end

    always_ff @(posedge ipv4_header) begin
        if (!rst_n) begin
            out_valid_q <= 1'b0;
        end else begin
            out_valid_q <= beat_valid;
        end
    end

    always_ff @(posedge ipv4_header) begin
        out_hdr_q   <= stamped_hdr;
        out_fault_q <= screened.fault;
    end

    ////////////////////
    // Counters

    // Saturate at all ones
    always_ff @(posedge ipv4_header) begin
        if (!rst_n) begin
            clean_q <= '0;
            fault_q <= '0;
        end else if (beat_valid) begin
            if (beat_clean && clean_q != '1) begin
                clean_q <= clean_q + 1'b1;
            end
            if (!beat_clean && fault_q != '1) begin
                fault_q <= fault_q + 1'b1;
            end
        end
    end

    assign hdr_out     = '{valid: out_valid_q, hdr: out_hdr_q, fault: out_fault_q};
    assign clean_count = clean_q;
    assign fault_count = fault_q;

endmodule

/* hdl/ipv4_hdr_stamper.sv */
////////////////////
// IPv4 header stamper top level
////////////////////

module ipv4_hdr_stamper (
    input  logic                          ipv4_header,
    input  logic                          rst_n,
    input  ipv4_stamp_pkg::hdr_beat_t     hdr_in,
    output ipv4_stamp_pkg::stamped_beat_t hdr_out,
    output ipv4_stamp_pkg::hdr_count_t    clean_count,
    output ipv4_stamp_pkg::hdr_count_t    fault_count
);

    import ipv4_stamp_pkg::*;

    // Two-cycle paths, aligned at the merge
    chksum_beat_t   chksum;
    screened_beat_t screened;

    // Checksum path
    ipv4_checksum_gen i_ipv4_checksum_gen (
        .ipv4_header (ipv4_header),
        .rst_n       (rst_n),
        .hdr_in      (hdr_in),
        .chksum      (chksum)
    );

    // Field screen path
    ipv4_hdr_screen i_ipv4_hdr_screen (
        .ipv4_header (ipv4_header),
        .rst_n       (rst_n),
        .hdr_in      (hdr_in),
        .screened    (screened)
    );

    // One more register stage
    ipv4_hdr_merge i_ipv4_hdr_merge (
        .ipv4_header (ipv4_header),
        .rst_n       (rst_n),
        .chksum      (chksum),
        .screened    (screened),
        .hdr_out     (hdr_out),
        .clean_count (clean_count),
        .fault_count (fault_count)
    );

endmodule

/* testbench/tb_ipv4_hdr_stamper.sv */
////////////////////
// Testbench for the IPv4 header stamper with random headers,
// a reference model, a scoreboard queue and the closing report
////////////////////

module tb_ipv4_hdr_stamper;

    timeunit 1ns;
    timeprecision 1ps;

    import ipv4_stamp_pkg::*;

    ////////////////////
    // Run constants

    localparam int unsigned SEED          = 32'h59aa2f03;
    localparam int          RESET_CYCLES  = 4;
    localparam int          NUM_CYCLES    = 2000;
    localparam int          DRAIN_TIMEOUT = 50;
    localparam int unsigned LATENCY       = 3;

    // One scoreboard entry
    typedef struct {
        ipv4_hdr_t   hdr;
        hdr_fault_t  fault;
        int unsigned due;
    } exp_beat_t;

    logic          ipv4_header = 1'b0;
    logic          rst_n;
    hdr_beat_t     hdr_in;
    stamped_beat_t hdr_out;
    hdr_count_t    clean_count;
    hdr_count_t    fault_count;

    exp_beat_t     expected[$];
    hdr_count_t    clean_exp;
    hdr_count_t    fault_exp;
    int unsigned   cycle;
    int unsigned   checked;
    int unsigned   value_errors;
    int unsigned   other_errors;

    ipv4_hdr_stamper i_ipv4_hdr_stamper (
        .ipv4_header (ipv4_header),
        .rst_n       (rst_n),
        .hdr_in      (hdr_in),
        .hdr_out     (hdr_out),
        .clean_count (clean_count),
        .fault_count (fault_count)
    );

    // 20 ns period
    always #10 ipv4_header = ~ipv4_header;

    ////////////////////
    // Compare tasks

    task automatic check_header(input string name, input ipv4_hdr_t exp, input ipv4_hdr_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_fault(input string name, input hdr_fault_t exp, input hdr_fault_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input hdr_count_t exp, input hdr_count_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp, act);
        end
    endtask

    ////////////////////
    // Reference model

    // Ones'-complement sum of nine words, checksum word skipped
    function automatic ip_chksum_t model_checksum(input ipv4_hdr_t h);
        logic [31:0] acc;
        acc = '0;
        for (int w = 0; w < 10; w++) begin
            // Word 4 is bits 79..64
            if (w != 4) begin
                acc = acc + {16'd0, h[w*16 +: 16]};
            end
        end
        while (acc[31:16] != 16'd0) begin
            acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
        end
        return ~acc[15:0];
    endfunction

    function automatic hdr_fault_t model_fault(input ipv4_hdr_t h);
        hdr_fault_t f;
        f                = '0;
        f[FAULT_VERSION] = (h[159:156] != IPV4_VERSION);
        f[FAULT_IHL]     = (h[155:152] != IPV4_IHL_MIN);
        f[FAULT_TTL]     = (h[95:88] == 8'd0);
        // Short length or reserved flag
        f[FAULT_LENGTH]  = (h[143:128] < IPV4_MIN_LENGTH) || h[111];
        return f;
    endfunction

    ////////////////////
    // Stimulus

    // About one in four headers gets one or more bad fields
    function automatic ipv4_hdr_t random_header();
        ipv4_hdr_t  h;
        logic [3:0] bad;
        for (int i = 0; i < 5; i++) begin
            h[i*32 +: 32] = $urandom();
        end
        h[159:156] = 4'd4;
        h[155:152] = 4'd5;
        h[143:128] = 16'(20 + $urandom_range(0, 1480));
        h[111]     = 1'b0;
        h[95:88]   = 8'($urandom_range(1, 255));
        if ($urandom_range(0, 3) == 0) begin
            bad = 4'($urandom_range(1, 15));
            if (bad[0]) begin
                h[159:156] = 4'($urandom_range(0, 15));
                if (h[159:156] == 4'd4) h[159:156] = 4'd6;
            end
            if (bad[1]) begin
                h[155:152] = 4'($urandom_range(0, 15));
                if (h[155:152] == 4'd5) h[155:152] = 4'd15;
            end
            if (bad[2]) h[95:88] = 8'd0;
            if (bad[3]) begin
                if ($urandom_range(0, 1) == 0) h[143:128] = 16'($urandom_range(0, 19));
                else h[111] = 1'b1;
            end
        end
        return h;
    endfunction

    // Random valid gives gaps and back-to-back runs
    task automatic drive_beat();
        exp_beat_t exp;
        ipv4_hdr_t h;
        logic      v;
        v = ($urandom_range(0, 3) != 0);
        h = random_header();
        hdr_in = '{valid: v, hdr: h};
        if (v) begin
            exp.hdr        = h;
            exp.hdr[79:64] = model_checksum(h);
            exp.fault      = model_fault(h);
            exp.due        = cycle + LATENCY;
            expected.push_back(exp);
            if (exp.fault == '0 && clean_exp != '1) clean_exp = clean_exp + hdr_count_t'(1);
            if (exp.fault != '0 && fault_exp != '1) fault_exp = fault_exp + hdr_count_t'(1);
        end
    endtask

    ////////////////////
    // Scoreboard

    task automatic sample_outputs();
        exp_beat_t exp;
        // Beats whose cycle passed with no output
        while (expected.size() > 0 && expected[0].due < cycle) begin
            other_errors++;
            $display("Output beat due at cycle %0d never appeared", expected[0].due);
            expected.delete(0);
        end
        if (hdr_out.valid === 1'b1) begin
            if (expected.size() == 0) begin
                other_errors++;
                $display("Unexpected output beat at cycle %0d", cycle);
            end else begin
                exp = expected.pop_front();
                if (exp.due != cycle) begin
                    other_errors++;
                    $display("Output beat at cycle %0d was due at cycle %0d", cycle, exp.due);
                end
                check_header("hdr_out.hdr", exp.hdr, hdr_out.hdr);
                check_fault("hdr_out.fault", exp.fault, hdr_out.fault);
                checked++;
            end
        end else if (hdr_out.valid !== 1'b0) begin
            other_errors++;
            $display("hdr_out valid is unknown at cycle %0d", cycle);
        end
    endtask

    // Sample first, then drive, on each falling edge
    task automatic next_cycle();
        @(negedge ipv4_header);
        cycle++;
        sample_outputs();
    endtask

    ////////////////////
    // Main sequence

    initial begin
        int waited;
        rst_n        = 1'b0;
        hdr_in       = '0;
        clean_exp    = '0;
        fault_exp    = '0;
        cycle        = 0;
        checked      = 0;
        value_errors = 0;
        other_errors = 0;
        void'($urandom(SEED));

        repeat (RESET_CYCLES) @(posedge ipv4_header);
        @(negedge ipv4_header);
        // Outputs idle under reset
        if (hdr_out.valid !== 1'b0) begin
            other_errors++;
            $display("hdr_out valid is not low after reset");
        end
        check_count("clean_count", '0, clean_count);
        check_count("fault_count", '0, fault_count);
        rst_n = 1'b1;

        for (int n = 0; n < NUM_CYCLES; n++) begin
            next_cycle();
            drive_beat();
        end
        // Last beat is taken on the next rising edge
        next_cycle();
        hdr_in = '0;

        // Drain the pipeline
        waited = 0;
        while (expected.size() > 0 && waited < DRAIN_TIMEOUT) begin
            next_cycle();
            waited++;
        end
        if (expected.size() > 0) begin
            other_errors++;
            $display("Timed out with %0d output beats still missing", expected.size());
        end
        // Idle cycles catch stray beats
        for (int n = 0; n < 4; n++) begin
            next_cycle();
        end

        check_count("clean_count", clean_exp, clean_count);
        check_count("fault_count", fault_exp, fault_count);

        $display("Checked %0d beats, %0d value errors, %0d other errors",
                 checked, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* ipv4_hdr_stamper.f */
hdl/ipv4_stamp_pkg.sv
hdl/ipv4_checksum_gen.sv
hdl/ipv4_hdr_screen.sv
hdl/ipv4_hdr_merge.sv
hdl/ipv4_hdr_stamper.sv
testbench/tb_ipv4_hdr_stamper.sv

/* Makefile */
# Verilator build and run of the IPv4 header stamper testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_ipv4_hdr_stamper
FILELIST  := ipv4_hdr_stamper.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, then search the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
